// File: src/corr_pkg.sv
`default_nettype none

package corr_pkg;

   // ------------------------------------------------------------
   // Array geometry
   // ------------------------------------------------------------
   localparam int ANT_NUM       = 4;   // Antennas, one sign bit each
   localparam int PAIR_NUM      = 6;   // All baselines of four antennas
   localparam int PAIRS_PER_BLK = 3;  // Baselines served by one correlator block

   // Baseline table, pair p correlates PAIR_A[p] with PAIR_B[p]
   // Order is (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
   localparam int PAIR_A [PAIR_NUM] = '{0, 0, 0, 1, 1, 2};
   localparam int PAIR_B [PAIR_NUM] = '{1, 2, 3, 2, 3, 3};

   // ------------------------------------------------------------
   // Read bus address map
   // ------------------------------------------------------------
   // Low bits pick a word inside a block
   // Word 2k is the real count of pair k, word 2k+1 the imaginary one
   localparam int ADR_W   = 6;  // Full bus address
   localparam int DEV_LSB = 3;  // Device field starts here, also the word width
   localparam int DEV_W   = 3;  // Device field width
   localparam int DEV_NUM = 2;  // Correlator blocks mapped on the bus

endpackage

`default_nettype wire

// File: src/quad_sampler.sv
`default_nettype none

module quad_sampler (
   input  wire logic                        clk_i,
   input  wire logic                        rst,
   input  wire logic                        enable_i,   // Sample is present this cycle
   input  wire logic [corr_pkg::ANT_NUM-1:0] antenna_i, // Sign bit per antenna
   output      logic                        valid_o,    // re_o and im_o are new
   output      logic [corr_pkg::ANT_NUM-1:0] re_o,
   output      logic [corr_pkg::ANT_NUM-1:0] im_o
);

   // ------------------------------------------------------------
   // Capture and quadrature delay
   // ------------------------------------------------------------
   // The imaginary stream is simply the prior captured sample,
   // a crude stand-in for a quarter-period shift
   always_ff @(posedge clk_i) begin
      if (rst) begin
         valid_o <= 1'b0;
         re_o    <= '0;
         im_o    <= '0;        // No history yet
      end else begin
         valid_o <= enable_i;  // One strobe per captured sample
         if (enable_i) begin
            re_o <= antenna_i; // New real sample
            im_o <= re_o;      // Shift last real into imaginary
         end
      end
   end

   // Outputs hold their value between captures, only valid_o
   // tells the correlators when to count

endmodule

`default_nettype wire

// File: src/bank_switch.sv
`default_nettype none

module bank_switch #(
   parameter int ACC_W = 16
) (
   input  wire logic             clk_i,
   input  wire logic             rst,
   input  wire logic             valid_i,     // Sample strobe from the sampler
   input  wire logic [ACC_W-1:0] blocksize_i, // Integration length minus one
   output      logic             swap_o,      // One-cycle bank swap pulse
   output      logic             bank_o       // Current bank index
);

   // ------------------------------------------------------------
   // Sample counter
   // ------------------------------------------------------------
   logic [ACC_W-1:0] cnt_q;  // Samples already in this integration
   logic             last;   // This valid closes the integration

   assign last = valid_i && (cnt_q == blocksize_i);

   always_ff @(posedge clk_i) begin
      if (rst) begin
         cnt_q <= '0;
      end else if (last) begin
         cnt_q <= '0;          // Next valid starts a fresh block
      end else if (valid_i) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // ------------------------------------------------------------
   // Swap pulse and bank index
   // ------------------------------------------------------------
   // Both change on the cycle after the closing sample, so the
   // accumulators already hold that sample when swap is seen
   always_ff @(posedge clk_i) begin
      if (rst) begin
         swap_o <= 1'b0;
         bank_o <= 1'b0;
      end else begin
         swap_o <= last;       // High for exactly one cycle
         if (last) begin
            bank_o <= ~bank_o; // Flip read-out bank
         end
      end
   end

   // A valid landing in the swap cycle is counted normally above,
   // it belongs to the new integration

endmodule

`default_nettype wire

// File: src/correlator_block.sv
`default_nettype none

module correlator_block #(
   parameter int ACC_W      = 16,
   parameter int FIRST_PAIR = 0   // First entry of the pair table for this block
) (
   input  wire logic                          clk_i,
   input  wire logic                          rst,
   input  wire logic                          valid_i,  // New sample this cycle
   input  wire logic [corr_pkg::ANT_NUM-1:0]  re_i,
   input  wire logic [corr_pkg::ANT_NUM-1:0]  im_i,
   input  wire logic                          swap_i,   // Close integration
   input  wire logic                          stb_i,    // Read strobe from decoder
   input  wire logic [corr_pkg::DEV_LSB-1:0]  word_i,   // Word inside this block
   output      logic                          ack_o,
   output      logic [ACC_W-1:0]              dat_o
);

   localparam int NP = corr_pkg::PAIRS_PER_BLK;

   // ------------------------------------------------------------
   // Sign agreement per pair
   // ------------------------------------------------------------
   logic [NP-1:0] agree_re;  // re(a) == re(b)
   logic [NP-1:0] agree_im;  // re(a) == im(b)

   for (genvar k = 0; k < NP; k++) begin : g_pair
      localparam int A = corr_pkg::PAIR_A[FIRST_PAIR + k];  // First antenna
      localparam int B = corr_pkg::PAIR_B[FIRST_PAIR + k];  // Second antenna

      // XNOR of the sign bits, one means the signs agree
      assign agree_re[k] = ~(re_i[A] ^ re_i[B]);
      assign agree_im[k] = ~(re_i[A] ^ im_i[B]);
   end

   // ------------------------------------------------------------
   // Accumulators and read-out bank
   // ------------------------------------------------------------
   logic [ACC_W-1:0] acc_re  [NP];  // Running counts
   logic [ACC_W-1:0] acc_im  [NP];
   logic [ACC_W-1:0] bank_re [NP];  // Totals of the last closed integration
   logic [ACC_W-1:0] bank_im [NP];

   always_ff @(posedge clk_i) begin
      if (rst) begin
         for (int k = 0; k < NP; k++) begin
            acc_re[k]  <= '0;
            acc_im[k]  <= '0;
            bank_re[k] <= '0;   // Reads return zero until the first swap
            bank_im[k] <= '0;
         end
      end else begin
         for (int k = 0; k < NP; k++) begin
            if (swap_i) begin
               bank_re[k] <= acc_re[k];   // Totals include the closing sample
               bank_im[k] <= acc_im[k];
               // Restart, keeping a sample that arrives with the swap
               acc_re[k]  <= valid_i ? ACC_W'(agree_re[k]) : '0;
               acc_im[k]  <= valid_i ? ACC_W'(agree_im[k]) : '0;
            end else if (valid_i) begin
               acc_re[k]  <= acc_re[k] + ACC_W'(agree_re[k]);
               acc_im[k]  <= acc_im[k] + ACC_W'(agree_im[k]);
            end
         end
      end
   end

   // ------------------------------------------------------------
   // Read port
   // ------------------------------------------------------------
   logic [1:0]       pair_sel;  // Pair index from the word address
   logic [ACC_W-1:0] rd_word;   // Addressed read-out word

   assign pair_sel = word_i[2:1];

   always_comb begin
      rd_word = '0;             // Words past the last pair read as zero
      for (int k = 0; k < NP; k++) begin
         if (pair_sel == k) begin
            rd_word = word_i[0] ? bank_im[k] : bank_re[k];
         end
      end
   end

   // Acknowledge one cycle after the strobe, data alongside it
   always_ff @(posedge clk_i) begin
      if (rst) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= stb_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (stb_i) begin
         dat_o <= rd_word;      // Held until the next read
      end
   end

endmodule

`default_nettype wire

// File: src/bus_decode.sv
`default_nettype none

module bus_decode #(
   parameter int ACC_W = 16
) (
   input  wire logic                                      clk_i,
   input  wire logic                                      rst,
   input  wire logic                                      stb_i,     // Host read strobe
   input  wire logic [corr_pkg::ADR_W-1:0]                adr_i,
   input  wire logic [corr_pkg::DEV_NUM-1:0]              blk_ack_i,
   input  wire logic [corr_pkg::DEV_NUM-1:0][ACC_W-1:0]   blk_dat_i,
   output      logic [corr_pkg::DEV_NUM-1:0]              blk_stb_o, // One-hot
   output      logic [corr_pkg::DEV_LSB-1:0]              word_o,
   output      logic                                      ack_o,
   output      logic                                      err_o,     // Unmapped device
   output      logic [ACC_W-1:0]                          dat_o
);

   // ------------------------------------------------------------
   // Device select
   // ------------------------------------------------------------
   logic [corr_pkg::DEV_W-1:0] dev;    // Device field of the current address
   logic [corr_pkg::DEV_W-1:0] dev_q;  // Device of the read in flight

   assign dev = adr_i[corr_pkg::DEV_LSB +: corr_pkg::DEV_W];

   always_ff @(posedge clk_i) begin
      if (rst) begin
         blk_stb_o <= '0;
         err_o     <= 1'b0;
         dev_q     <= '0;
      end else begin
         for (int d = 0; d < corr_pkg::DEV_NUM; d++) begin
            blk_stb_o[d] <= stb_i && (dev == d);  // At most one block
         end
         err_o <= stb_i && (dev >= corr_pkg::DEV_NUM); // Nothing mapped there
         if (stb_i) begin
            dev_q <= dev;       // Remember where the answer comes from
         end
      end
   end

   // Word address travels with the strobe
   always_ff @(posedge clk_i) begin
      if (stb_i) begin
         word_o <= adr_i[corr_pkg::DEV_LSB-1:0];
      end
   end

   // ------------------------------------------------------------
   // Return path
   // ------------------------------------------------------------
   // Blocks register their reply, so this mux just picks the one
   // addressed earlier
   always_comb begin
      ack_o = 1'b0;
      dat_o = '0;
      for (int d = 0; d < corr_pkg::DEV_NUM; d++) begin
         if (dev_q == d) begin
            ack_o = blk_ack_i[d];
            dat_o = blk_dat_i[d];
         end
      end
   end

endmodule

`default_nettype wire

// File: src/corr_top.sv
`default_nettype none

module corr_top #(
   parameter int ACC_W = 16  // Count and bus data width
) (
   input  wire logic                         clk_i,
   input  wire logic                         rst,

   // Antenna samples
   input  wire logic                         enable_i,    // Acquisition enabled
   input  wire logic [corr_pkg::ANT_NUM-1:0] antenna_i,
   input  wire logic [ACC_W-1:0]             blocksize_i, // Samples per block minus one
   output      logic                         strobe_o,    // Sample reached correlators
   output      logic                         bank_o,
   output      logic                         switch_o,    // Integration closed

   // Read bus
   input  wire logic                         stb_i,
   input  wire logic [corr_pkg::ADR_W-1:0]   adr_i,
   output      logic                         ack_o,
   output      logic                         err_o,
   output      logic [ACC_W-1:0]             dat_o
);

   logic [corr_pkg::ANT_NUM-1:0]            re;       // Real sign stream
   logic [corr_pkg::ANT_NUM-1:0]            im;       // Delayed stream
   logic [corr_pkg::DEV_NUM-1:0]            blk_stb;  // Per-block read strobe
   logic [corr_pkg::DEV_LSB-1:0]            word;
   logic [corr_pkg::DEV_NUM-1:0]            blk_ack;
   logic [corr_pkg::DEV_NUM-1:0][ACC_W-1:0] blk_dat;

   // ------------------------------------------------------------
   // Sample path
   // ------------------------------------------------------------
   quad_sampler u_sampler (
      .clk_i     (clk_i),
      .rst       (rst),
      .enable_i  (enable_i),
      .antenna_i (antenna_i),
      .valid_o   (strobe_o),  // Also the correlator count enable
      .re_o      (re),
      .im_o      (im)
   );

   bank_switch #(.ACC_W(ACC_W)) u_switch (
      .clk_i       (clk_i),
      .rst         (rst),
      .valid_i     (strobe_o),
      .blocksize_i (blocksize_i),
      .swap_o      (switch_o),  // Drives both blocks
      .bank_o      (bank_o)
   );

   // ------------------------------------------------------------
   // Correlator blocks, pairs 0..2 and 3..5
   // ------------------------------------------------------------
   correlator_block #(.ACC_W(ACC_W), .FIRST_PAIR(0)) blk0 (
      .clk_i   (clk_i),
      .rst     (rst),
      .valid_i (strobe_o),
      .re_i    (re),
      .im_i    (im),
      .swap_i  (switch_o),
      .stb_i   (blk_stb[0]),
      .word_i  (word),
      .ack_o   (blk_ack[0]),
      .dat_o   (blk_dat[0])
   );

   correlator_block #(.ACC_W(ACC_W), .FIRST_PAIR(3)) blk1 (
      .clk_i   (clk_i),
      .rst     (rst),
      .valid_i (strobe_o),
      .re_i    (re),
      .im_i    (im),
      .swap_i  (switch_o),
      .stb_i   (blk_stb[1]),
      .word_i  (word),
      .ack_o   (blk_ack[1]),
      .dat_o   (blk_dat[1])
   );

   // ------------------------------------------------------------
   // Read bus decoder
   // ------------------------------------------------------------
   bus_decode #(.ACC_W(ACC_W)) u_decode (
      .clk_i     (clk_i),
      .rst       (rst),
      .stb_i     (stb_i),
      .adr_i     (adr_i),
      .blk_ack_i (blk_ack),
      .blk_dat_i (blk_dat),
      .blk_stb_o (blk_stb),
      .word_o    (word),
      .ack_o     (ack_o),
      .err_o     (err_o),
      .dat_o     (dat_o)
   );

endmodule

`default_nettype wire

// File: verif/corr_tb.sv
`default_nettype none

module corr_tb;

   localparam int ACC_W = 16;

   logic                         clk_i;
   logic                         rst;
   logic                         enable_i;
   logic [corr_pkg::ANT_NUM-1:0] antenna_i;
   logic [ACC_W-1:0]             blocksize_i;
   logic                         stb_i;
   logic [corr_pkg::ADR_W-1:0]   adr_i;
   logic                         strobe_o;
   logic                         bank_o;
   logic                         switch_o;
   logic                         ack_o;
   logic                         err_o;
   logic [ACC_W-1:0]             dat_o;

   // Records from the cases file with one entry per line
   byte   kind_q  [$];
   int    arg_a_q [$];
   int    arg_b_q [$];
   string name_q  [$];

   string cur_name;
   int    errors    = 0;
   int    checks    = 0;
   int    err_start = 0;     // Error count when the test began
   int    cycles    = 0;
   int    limit     = 100000; // Tightened once the file is parsed
   int    seg_cnt   = 0;     // Valid samples since the last switch_o
   int    switches  = 0;
   int    n_en      = 0;     // Enabled samples driven in this test
   int    bsize     = 0;
   logic  mon_on    = 1'b0;
   logic  bank_prev = 1'b0;

   corr_top #(.ACC_W(ACC_W)) dut0 (
      .clk_i       (clk_i),
      .rst         (rst),
      .enable_i    (enable_i),
      .antenna_i   (antenna_i),
      .blocksize_i (blocksize_i),
      .strobe_o    (strobe_o),
      .bank_o      (bank_o),
      .switch_o    (switch_o),
      .stb_i       (stb_i),
      .adr_i       (adr_i),
      .ack_o       (ack_o),
      .err_o       (err_o),
      .dat_o       (dat_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;   // Period 4
   end

   initial begin : watchdog
      while (cycles < limit) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("Timeout: the run passed its limit of %0d cycles", limit);
      $display("Checks failed");
      $finish;
   end

   task automatic note_failure(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   // ------------------------------------------------------------
   // Integration monitor sampling settled outputs at the falling edge
   // ------------------------------------------------------------
   always @(negedge clk_i) begin
      if (mon_on) begin
         if (switch_o) begin
            checks++;
            switches++;
            if (seg_cnt != bsize + 1) begin
               note_failure($sformatf("** Error %s: samples per integration expected %0d actual %0d",
                                      cur_name, bsize + 1, seg_cnt));
            end
            if (bank_o == bank_prev) begin
               note_failure($sformatf("%s: bank_o did not toggle at switch_o", cur_name));
            end
            seg_cnt = strobe_o ? 1 : 0;   // A sample in the swap cycle opens the next block
         end else begin
            if (bank_o != bank_prev) begin
               note_failure($sformatf("%s: bank_o changed without switch_o", cur_name));
            end
            seg_cnt += strobe_o ? 1 : 0;
         end
         bank_prev = bank_o;
      end
   end

   // ------------------------------------------------------------
   // Stimulus tasks driving on the falling edge
   // ------------------------------------------------------------
   task automatic reset_dut(input int bs);
      mon_on      = 1'b0;
      rst         = 1'b1;
      enable_i    = 1'b0;
      stb_i       = 1'b0;
      blocksize_i = bs[ACC_W-1:0];
      repeat (16) @(negedge clk_i);
      rst       = 1'b0;
      seg_cnt   = 0;
      switches  = 0;
      n_en      = 0;
      bsize     = bs;
      bank_prev = 1'b0;
      mon_on    = 1'b1;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge clk_i);
         enable_i = 1'b0;
      end
   endtask

   task automatic drive_sample(input int val, input int en);
      @(negedge clk_i);
      antenna_i = val[corr_pkg::ANT_NUM-1:0];
      enable_i  = en[0];
      n_en     += en;
   endtask

   task automatic bus_read(input int adr, input int exp, input bit want_err);
      int wait_cyc;
      bit late_ack;
      @(negedge clk_i);
      stb_i = 1'b1;                   // Single-cycle strobe
      adr_i = adr[corr_pkg::ADR_W-1:0];
      @(negedge clk_i);
      stb_i    = 1'b0;
      wait_cyc = 1;
      while (!ack_o && !err_o && wait_cyc < 8) begin
         @(negedge clk_i);
         wait_cyc++;
      end
      checks++;
      if (!ack_o && !err_o) begin
         note_failure($sformatf("%s: no ack_o or err_o for address %02h", cur_name, adr));
      end else if (want_err) begin
         if (!err_o || wait_cyc != 1) begin
            note_failure($sformatf("%s: err_o for address %02h missing one cycle after the strobe",
                                   cur_name, adr));
         end
         late_ack = 1'b0;
         repeat (3) begin
            @(negedge clk_i);
            late_ack |= ack_o;
         end
         if (late_ack) begin
            note_failure($sformatf("%s: ack_o followed unmapped address %02h", cur_name, adr));
         end
      end else if (err_o || wait_cyc != 2) begin
         note_failure($sformatf("%s: address %02h answered %0d cycles after the strobe, not 2",
                                cur_name, adr, wait_cyc));
      end else if (dat_o != exp[ACC_W-1:0]) begin
         note_failure($sformatf("** Error %s: address %02h expected %0d actual %0d",
                                cur_name, adr, exp, dat_o));
      end
      @(negedge clk_i);               // Keeps strobes at least three cycles apart
   endtask

   task automatic finish_test();
      int exp_sw;
      int exp_rem;
      idle(4);                        // Last swap lands two cycles after the sample
      exp_sw  = n_en / (bsize + 1);
      exp_rem = n_en % (bsize + 1);   // Enabled samples still in the open integration
      checks += 3;
      if (switches != exp_sw) begin
         note_failure($sformatf("** Error %s: switch_o pulses expected %0d actual %0d",
                                cur_name, exp_sw, switches));
      end
      if (bank_o != exp_sw[0]) begin
         note_failure($sformatf("** Error %s: bank_o expected %0d actual %0d",
                                cur_name, exp_sw[0], bank_o));
      end
      if (seg_cnt != exp_rem) begin
         note_failure($sformatf("** Error %s: trailing strobe_o count expected %0d actual %0d",
                                cur_name, exp_rem, seg_cnt));
      end
      $display("test %-15s %s", cur_name, (errors == err_start) ? "ok" : "FAILED");
   endtask

   // ------------------------------------------------------------
   // Parse the cases file and run every record
   // ------------------------------------------------------------
   initial begin
      int               fd;
      int               n;
      int               a;
      int               b;
      int               samples;
      int               reads;
      int               cur_test;
      bit               pending;
      byte              kind;
      logic [8*24-1:0]  word;
      logic [8*160-1:0] rest;
      rst         = 1'b1;
      enable_i    = 1'b0;
      antenna_i   = '0;
      blocksize_i = '0;
      stb_i       = 1'b0;
      adr_i       = '0;
      samples     = 0;
      reads       = 0;
      cur_test    = -1;
      pending     = 1'b0;
      fd = $fopen("verif/corr_cases.txt", "r");
      if (fd == 0) begin
         note_failure("Cannot open verif/corr_cases.txt for reading");
      end else begin
         while ($fscanf(fd, " %c", kind) == 1) begin
            a    = 0;
            b    = 0;
            n    = 0;
            word = '0;
            case (kind)
               "#": n = $fgets(rest, fd);   // Comment line
               "T": n = $fscanf(fd, "%s %d", word, a);
               "S": n = $fscanf(fd, "%h %d", a, b);
               "R": n = $fscanf(fd, "%h %h", a, b);
               "E": n = $fscanf(fd, "%h", a);
               default: note_failure($sformatf("Unknown record %c in the cases file", kind));
            endcase
            if (kind != "#" && n != ((kind == "E") ? 1 : 2)) begin
               note_failure($sformatf("Record %c in the cases file has missing fields", kind));
            end
            if (kind == "T") name_q.push_back(string'(word));
            if (kind == "S") samples++;
            if (kind == "R" || kind == "E") reads++;
            if (kind != "#") begin
               kind_q.push_back(kind);
               arg_a_q.push_back(a);
               arg_b_q.push_back(b);
            end
         end
         $fclose(fd);
         limit = 40 * name_q.size() + 5 * samples + 12 * reads + 50;
         for (int i = 0; i < kind_q.size(); i++) begin
            case (kind_q[i])
               "T": begin
                  if (cur_test >= 0) finish_test();
                  cur_test++;
                  cur_name  = name_q[cur_test];
                  err_start = errors;
                  reset_dut(arg_a_q[i]);
               end
               "S": begin
                  drive_sample(arg_a_q[i], arg_b_q[i]);
                  pending = 1'b1;
               end
               default: begin           // R and E records
                  if (pending) idle(4);  // Let the pipeline settle first
                  pending = 1'b0;
                  bus_read(arg_a_q[i], arg_b_q[i], kind_q[i] == "E");
               end
            endcase
         end
         if (cur_test >= 0) finish_test();
      end
      $display("%0d tests, %0d checks, %0d errors", name_q.size(), checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/corr_cases.txt
# T name blocksize | S antenna_hex enable, bit a is antenna a | R addr_hex expected_hex
# E addr_hex expects err_o and no data
# Addr bits 5:3 pick the block, bits 2:0 the word, 2k real and 2k+1 imaginary of pair k
T reset_zero 3
R 00 0000
R 05 0000
R 07 0000
R 0D 0000
# Constant zero on every antenna, each count is blocksize+1
T all_equal 3
S 0 1
S 0 1
S 0 1
S 0 1
R 00 0004
R 03 0004
R 08 0004
R 0D 0004
# Mixed signs with a disabled sample in between
T mixed 2
S 5 1
S F 0
S A 1
S 3 1
R 00 0001
R 01 0002
R 02 0002
R 05 0002
R 09 0002
R 0C 0001
R 0D 0001
# Read-out holds while the second integration fills
T stable_readout 1
S F 1
S F 1
R 01 0001
R 02 0002
R 0A 0002
S 3 1
S C 0
R 01 0001
R 02 0002
S 3 1
R 01 0002
R 02 0000
R 03 0001
R 0A 0000
# Devices 2 and 7 are unmapped, a mapped read still answers after them
T bus_error 3
E 10
E 38
R 08 0000

// File: verilog.f
src/corr_pkg.sv
src/quad_sampler.sv
src/bank_switch.sv
src/correlator_block.sv
src/bus_decode.sv
src/corr_top.sv
verif/corr_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the correlator testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module corr_tb -f verilog.f -o corr_sim &&
./obj_dir/corr_sim | tee /dev/stderr | grep -q "All checks passed" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
